// ==== verilog/starfield_pkg.sv ====
// shared constants and types for the starfield design
// 480p display timing, LFSR settings, star layer settings

package starfield_pkg;

    // horizontal timing in pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;   // front porch
    localparam int H_SYNC   = 96;   // sync pulse width
    localparam int H_BP     = 48;   // back porch
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 525

    // pixel clocks per frame, 420000
    localparam int FRAME_PIXELS = H_TOTAL * V_TOTAL;
    localparam int FRAME_CNT_W  = $clog2(FRAME_PIXELS);        // restart counter width

    // screen coordinates
    localparam int CORDW = 10;
    typedef logic [CORDW-1:0] coord_t;

    // galois lfsr, x^21 + x^19 + 1
    localparam int LFSR_W = 21;
    typedef logic [LFSR_W-1:0] lfsr_t;
    localparam lfsr_t LFSR_TAPS = 21'h140000;  // bits 20 and 18

    // star brightness and output colour
    localparam int STAR_W = 8;
    typedef logic [STAR_W-1:0] star_t;
    localparam int COLR_W = 4;
    typedef logic [COLR_W-1:0] colr_t;

    // per-layer settings; negative inc shortens the frame, so the field drifts left
    localparam lfsr_t SF1_SEED = 21'h09A9A9;
    localparam int    SF1_INC  = -1;
    localparam lfsr_t SF1_MASK = 21'h000000;
    localparam lfsr_t SF2_SEED = 21'h0A9A9A;
    localparam int    SF2_INC  = -2;
    localparam lfsr_t SF2_MASK = 21'h000000;
    localparam lfsr_t SF3_SEED = 21'h1FFFFF;
    localparam int    SF3_INC  = -4;
    localparam lfsr_t SF3_MASK = 21'h0007FF;  // denser layer

endpackage

// ==== verilog/display_timing.sv ====
// display_timing: 640x480 at 60 Hz timing generator
// pixel and line counters, negative sync pulses, display enable

module display_timing import starfield_pkg::*; (
    input  logic clk_pix,   // pixel clock
    input  logic rst_n,     // async reset, active low
    output logic hsync,     // horizontal sync, active low
    output logic vsync,     // vertical sync, active low
    output logic de         // display enable, active area
);

    coord_t sx;  // horizontal position
    coord_t sy;  // vertical position

    logic line_end;   // last pixel of a line
    logic frame_end;  // last line of a frame

    assign line_end  = (sx == coord_t'(H_TOTAL - 1));
    assign frame_end = (sy == coord_t'(V_TOTAL - 1));

    // pixel counter
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;  // wrap at 800
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // line counter, steps once per line
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sy <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                sy <= '0;  // wrap at 525
            end else begin
                sy <= sy + 1'b1;
            end
        end
    end

    // decode straight from the counters, no extra register stage
    // the mixer registers these once, together with the colour
    always_comb begin
        // hsync low for pixels 656 to 751
        hsync = ~((sx >= coord_t'(H_ACTIVE + H_FP)) &&
                  (sx <  coord_t'(H_ACTIVE + H_FP + H_SYNC)));

        // vsync low for lines 490 and 491
        vsync = ~((sy >= coord_t'(V_ACTIVE + V_FP)) &&
                  (sy <  coord_t'(V_ACTIVE + V_FP + V_SYNC)));

        // visible area only
        de = (sx < coord_t'(H_ACTIVE)) && (sy < coord_t'(V_ACTIVE));
    end

endmodule

// ==== verilog/starfield.sv ====
// starfield: one layer of pseudo-random stars
// restart counter, 21-bit galois lfsr, star on and brightness decode

module starfield import starfield_pkg::*; #(
    parameter lfsr_t SEED = SF1_SEED,   // lfsr state at frame start
    parameter int    INC  = SF1_INC,    // frame length change, pixels per frame drift
    parameter lfsr_t MASK = SF1_MASK    // forces upper bits on, more stars
) (
    input  logic  clk_pix,   // pixel clock
    input  logic  rst_n,     // async reset, active low
    input  logic  run,       // high to let the layer drift
    output logic  sf_on,     // star at this pixel
    output star_t sf_star    // star brightness
);

    logic [FRAME_CNT_W-1:0] cnt;          // pixels since last restart
    logic [FRAME_CNT_W-1:0] restart_cnt;  // last count before restart
    logic                   restart;
    lfsr_t                  sf_reg;       // lfsr state
    lfsr_t                  sf_next;

    // shortened frame when running, exact frame when frozen
    always_comb begin
        if (run) begin
            restart_cnt = FRAME_CNT_W'(FRAME_PIXELS + INC - 1);
        end else begin
            restart_cnt = FRAME_CNT_W'(FRAME_PIXELS - 1);
        end
    end

    assign restart = (cnt == restart_cnt);

    // galois step, shift right and fold in the taps on a 1 out
    always_comb begin
        if (sf_reg[0]) begin
            sf_next = (sf_reg >> 1) ^ LFSR_TAPS;
        end else begin
            sf_next = sf_reg >> 1;
        end
    end

    // restart counter
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;                  // aligned with pixel (0,0)
        end else if (restart) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // lfsr, reloads the seed after the restart count
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sf_reg <= SEED;
        end else if (restart) begin
            sf_reg <= SEED;             // sequence starts over
        end else begin
            sf_reg <= sf_next;
        end
    end

    // star where bits 20:8 are all set, mask raises the hit rate
    assign sf_on   = &(sf_reg[LFSR_W-1:STAR_W] | MASK[LFSR_W-1:STAR_W]);
    assign sf_star = sf_reg[STAR_W-1:0];  // low byte as brightness

endmodule

// ==== verilog/star_mixer.sv ====
// star_mixer: layer priority and VGA output register
// picks the first layer that is on, blanks outside the active area

module star_mixer import starfield_pkg::*; (
    input  logic  clk_pix,     // pixel clock
    input  logic  rst_n,       // async reset, active low
    input  logic  hsync,       // sync from the timing block
    input  logic  vsync,
    input  logic  de,          // active area
    input  logic  sf1_on,      // layer 1 has a star
    input  logic  sf2_on,
    input  logic  sf3_on,
    input  star_t sf1_star,    // layer brightness
    input  star_t sf2_star,
    input  star_t sf3_star,
    output logic  vga_hsync,   // registered outputs
    output logic  vga_vsync,
    output colr_t vga_r,
    output colr_t vga_g,
    output colr_t vga_b
);

    colr_t starlight;  // brightness of the winning layer

    // fixed priority, layer 1 in front
    always_comb begin
        if (sf1_on) begin
            starlight = sf1_star[STAR_W-1 -: COLR_W];  // top nibble
        end else if (sf2_on) begin
            starlight = sf2_star[STAR_W-1 -: COLR_W];
        end else if (sf3_on) begin
            starlight = sf3_star[STAR_W-1 -: COLR_W];
        end else begin
            starlight = '0;  // empty sky
        end
    end

    // one register stage keeps sync and colour aligned
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;  // syncs idle high
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            vga_r     <= de ? starlight : '0;  // grey, same on every channel
            vga_g     <= de ? starlight : '0;
            vga_b     <= de ? starlight : '0;
        end
    end

endmodule

// ==== verilog/starfield_top.sv ====
// starfield_top: moving starfield on 640x480 VGA
// timing block, three star layers and the output mixer

module starfield_top import starfield_pkg::*; (
    input  logic  clk_pix,     // 25.175 MHz pixel clock
    input  logic  rst_n,       // async reset, active low
    input  logic  run,         // low freezes the field
    output logic  vga_hsync,   // horizontal sync, active low
    output logic  vga_vsync,   // vertical sync, active low
    output colr_t vga_r,       // 4-bit red
    output colr_t vga_g,       // 4-bit green
    output colr_t vga_b        // 4-bit blue
);

    // display timing
    logic hsync;
    logic vsync;
    logic de;

    display_timing u_display_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de)
    );

    // star layers, slowest first
    logic  sf1_on, sf2_on, sf3_on;
    star_t sf1_star, sf2_star, sf3_star;

    starfield #(.SEED(SF1_SEED), .INC(SF1_INC), .MASK(SF1_MASK)) u_sf1 (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .run     (run),
        .sf_on   (sf1_on),
        .sf_star (sf1_star)
    );

    starfield #(.SEED(SF2_SEED), .INC(SF2_INC), .MASK(SF2_MASK)) u_sf2 (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .run     (run),
        .sf_on   (sf2_on),
        .sf_star (sf2_star)
    );

    // fastest and densest layer, at the back
    starfield #(.SEED(SF3_SEED), .INC(SF3_INC), .MASK(SF3_MASK)) u_sf3 (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .run     (run),
        .sf_on   (sf3_on),
        .sf_star (sf3_star)
    );

    // priority select and output register
    star_mixer u_star_mixer (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .sf1_on    (sf1_on),
        .sf2_on    (sf2_on),
        .sf3_on    (sf3_on),
        .sf1_star  (sf1_star),
        .sf2_star  (sf2_star),
        .sf3_star  (sf3_star),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

// ==== dv/starfield_assert.sv ====
// starfield_assert: concurrent checks bound into starfield_top
// hsync pulse width, blanking after de, grey colour outputs

module starfield_assert import starfield_pkg::*; (
    input logic  clk_pix,
    input logic  rst_n,
    input logic  de,          // unregistered active area
    input logic  vga_hsync,
    input colr_t vga_r,
    input colr_t vga_g,
    input colr_t vga_b
);

    int low_len;  // consecutive low cycles of vga_hsync

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            low_len <= 0;
        end else if (!vga_hsync) begin
            low_len <= low_len + 1;
        end else begin
            low_len <= 0;
        end
    end

    // pulse ends after exactly H_SYNC cycles
    hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(vga_hsync) |-> (low_len == H_SYNC))
        else $error("hsync pulse width differs from %0d cycles", H_SYNC);

    hsync_max: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !vga_hsync |-> (low_len < H_SYNC))
        else $error("hsync stayed low longer than %0d cycles", H_SYNC);

    blank_out: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !de |=> ((vga_r == '0) && (vga_g == '0) && (vga_b == '0)))
        else $error("colour output not blank after de went low");

    grey_out: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (vga_r == vga_g) && (vga_g == vga_b))
        else $error("colour channels differ");

endmodule

bind starfield_top starfield_assert u_starfield_assert (
    .clk_pix   (clk_pix),
    .rst_n     (rst_n),
    .de        (de),
    .vga_hsync (vga_hsync),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
);

// ==== dv/starfield_tb.sv ====
// starfield_tb: testbench for the moving starfield top level
// clock, reset, test table, timing and lfsr reference model, compare tasks, watchdog

module starfield_tb import starfield_pkg::*; ();

    localparam int NUM_ROWS      = 4;
    localparam int RESET_CYCLES  = 3;
    localparam int ACTIVE_PIXELS = H_ACTIVE * V_ACTIVE;
    localparam int CLK_PERIOD    = 40;

    // test table: run value, frame count, expected frame repeat
    localparam int ROW_RUN    [NUM_ROWS] = '{0, 1, 0, 1};
    localparam int ROW_FRAMES [NUM_ROWS] = '{1, 3, 2, 2};
    localparam int ROW_REPEAT [NUM_ROWS] = '{1, 0, 1, 0};  // 1: each frame equals the last
    string row_name [NUM_ROWS] = '{"still_1", "drift_3", "still_2", "drift_2"};

    // layer settings for the model, priority order
    localparam lfsr_t LAYER_SEED [3] = '{SF1_SEED, SF2_SEED, SF3_SEED};
    localparam int    LAYER_INC  [3] = '{SF1_INC, SF2_INC, SF3_INC};
    localparam lfsr_t LAYER_MASK [3] = '{SF1_MASK, SF2_MASK, SF3_MASK};

    logic  clk_pix;
    logic  rst_n;
    logic  run;
    logic  vga_hsync;
    logic  vga_vsync;
    colr_t vga_r;
    colr_t vga_g;
    colr_t vga_b;

    // model state
    int    m_sx;
    int    m_sy;
    int    m_cnt  [3];   // restart counters
    lfsr_t m_lfsr [3];

    // expected outputs for the next clock
    logic  exp_hsync;
    logic  exp_vsync;
    logic  exp_de;
    colr_t exp_colr;
    int    exp_idx;      // pixel index in the active area

    colr_t prev_frame [ACTIVE_PIXELS];  // last frame as seen on the outputs
    bit    have_prev;
    int    diff_cnt;     // pixels changed since the last frame

    starfield_top u_starfield_top (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .run       (run),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_sync(input string test, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED %s %s: expected %b, actual %b",
                                     test, what, exp, act));
        end
    endtask

    task automatic check_colr(input string test, input string what, input colr_t exp,
                              input colr_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAILED %s %s: expected %h, actual %h",
                                     test, what, exp, act));
        end
    endtask

    // galois step, x^21 + x^19 + 1
    function automatic lfsr_t lfsr_step(input lfsr_t s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic layer_on(input lfsr_t s, input lfsr_t mask);
        lfsr_t bits;
        bits = s | mask;
        return &bits[LFSR_W-1:STAR_W];  // bits 20 to 8 all set
    endfunction

    task automatic model_reset();
        m_sx = 0;
        m_sy = 0;
        for (int i = 0; i < 3; i++) begin
            m_cnt[i]  = 0;
            m_lfsr[i] = LAYER_SEED[i];
        end
    endtask

    // outputs the dut should show after the next edge
    task automatic model_predict();
        bit found;
        found     = 1'b0;
        exp_hsync = !((m_sx >= H_ACTIVE + H_FP) && (m_sx < H_ACTIVE + H_FP + H_SYNC));
        exp_vsync = !((m_sy >= V_ACTIVE + V_FP) && (m_sy < V_ACTIVE + V_FP + V_SYNC));
        exp_de    = (m_sx < H_ACTIVE) && (m_sy < V_ACTIVE);
        exp_colr  = '0;
        for (int i = 0; i < 3; i++) begin
            if (!found && layer_on(m_lfsr[i], LAYER_MASK[i])) begin
                exp_colr = m_lfsr[i][STAR_W-1 -: COLR_W];  // top nibble of the star byte
                found    = 1'b1;
            end
        end
        if (!exp_de) begin
            exp_colr = '0;  // blanking
        end
        exp_idx = m_sy * H_ACTIVE + m_sx;
    endtask

    task automatic model_advance(input logic run_val);
        int limit;
        for (int i = 0; i < 3; i++) begin
            limit = run_val ? FRAME_PIXELS + LAYER_INC[i] - 1 : FRAME_PIXELS - 1;
            if (m_cnt[i] == limit) begin
                m_cnt[i]  = 0;
                m_lfsr[i] = LAYER_SEED[i];  // restart
            end else begin
                m_cnt[i]  = m_cnt[i] + 1;
                m_lfsr[i] = lfsr_step(m_lfsr[i]);
            end
        end
        if (m_sx == H_TOTAL - 1) begin
            m_sx = 0;
            m_sy = (m_sy == V_TOTAL - 1) ? 0 : m_sy + 1;
        end else begin
            m_sx = m_sx + 1;
        end
    endtask

    task automatic check_reset_outputs(input string test);
        check_sync(test, "hsync in reset", 1'b1, vga_hsync);
        check_sync(test, "vsync in reset", 1'b1, vga_vsync);
        check_colr(test, "red in reset", '0, vga_r);
        check_colr(test, "green in reset", '0, vga_g);
        check_colr(test, "blue in reset", '0, vga_b);
    endtask

    // frozen rows repeat, drifting rows must change somewhere
    task automatic compare_frame(input int row);
        if (have_prev) begin
            if (ROW_REPEAT[row] != 0) begin
                check_colr(row_name[row], "repeated pixel", prev_frame[exp_idx], vga_r);
            end else if (prev_frame[exp_idx] != vga_r) begin
                diff_cnt = diff_cnt + 1;
            end
        end
        prev_frame[exp_idx] = vga_r;
    endtask

    task automatic end_of_frame(input int row);
        if (have_prev && ROW_REPEAT[row] == 0 && diff_cnt == 0) begin
            report_failure($sformatf("%s: the picture did not move while run was high",
                                     row_name[row]));
        end
        have_prev = 1'b1;
        diff_cnt  = 0;
    endtask

    task automatic run_row(input int row);
        int   cycles;
        logic run_val;
        run_val = (ROW_RUN[row] != 0);
        cycles  = ROW_FRAMES[row] * FRAME_PIXELS;
        @(posedge clk_pix);
        #2;
        rst_n = 1'b0;
        run   = run_val;
        repeat (RESET_CYCLES) begin
            @(posedge clk_pix);
            #2;
            check_reset_outputs(row_name[row]);
        end
        rst_n = 1'b1;
        #1;
        check_reset_outputs(row_name[row]);  // no edge yet since release
        model_reset();
        have_prev = 1'b0;
        diff_cnt  = 0;
        for (int c = 0; c < cycles; c++) begin
            model_predict();
            @(posedge clk_pix);
            #2;
            check_sync(row_name[row], "hsync", exp_hsync, vga_hsync);
            check_sync(row_name[row], "vsync", exp_vsync, vga_vsync);
            check_colr(row_name[row], "red", exp_colr, vga_r);
            check_colr(row_name[row], "green", exp_colr, vga_g);
            check_colr(row_name[row], "blue", exp_colr, vga_b);
            if (exp_de) begin
                compare_frame(row);
            end
            model_advance(run_val);
            if ((c + 1) % FRAME_PIXELS == 0) begin
                end_of_frame(row);
            end
        end
    endtask

    // limit from the table length plus some slack
    initial begin : watchdog
        int limit;
        limit = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit = limit + ROW_FRAMES[i] * FRAME_PIXELS + 10;
        end
        limit = limit * CLK_PERIOD + 1000 * CLK_PERIOD;
        #(limit);
        report_failure($sformatf("timeout: the run did not finish within %0d time units",
                                 limit));
    end

    initial begin : main
        clk_pix = 1'b0;
        rst_n   = 1'b0;
        run     = 1'b0;
        for (int row = 0; row < NUM_ROWS; row++) begin
            run_row(row);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== starfield_top.f ====
verilog/starfield_pkg.sv
verilog/display_timing.sv
verilog/starfield.sv
verilog/star_mixer.sv
verilog/starfield_top.sv
dv/starfield_assert.sv
dv/starfield_tb.sv

// ==== Makefile ====
# Verilator build and run for the starfield testbench

SRCS = verilog/starfield_pkg.sv \
       verilog/display_timing.sv \
       verilog/starfield.sv \
       verilog/star_mixer.sv \
       verilog/starfield_top.sv \
       dv/starfield_assert.sv \
       dv/starfield_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vstarfield_tb: $(SRCS) starfield_top.f
	verilator --binary --timing --assert -j 0 --top-module starfield_tb \
	    -f starfield_top.f -o Vstarfield_tb

run: obj_dir/Vstarfield_tb
	./obj_dir/Vstarfield_tb 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log; then \
	    echo "simulation failed"; exit 1; \
	fi
	@grep -q "All tests passed!" sim.log || { echo "simulation stopped early"; exit 1; }

clean:
	rm -rf obj_dir sim.log
